/* tb.f */
design/pipe_ctrl_pkg.sv
design/forwarding_unit.sv
design/flush_tracker.sv
design/sf_controller.sv
verification/sf_controller_properties.sv
verification/tb_sf_controller.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := tb_sf_controller
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* verification/tb_sf_controller.sv */
module tb_sf_controller import pipe_ctrl_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 5;
    localparam int NROWS           = 33;
    localparam int NOUT            = 22;
    localparam int WATCHDOG_MARGIN = 10;   // Spare cycles beyond reset and table
    localparam int WATCHDOG_TIME   = (NROWS + RESET_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD;

    localparam logic [OPC_W-1:0] OPC_OP = 7'b0110011;   // R-type, anything but JALR

    // One table row of DUT inputs
    typedef struct packed {
        logic [7:0]  ctl;     // jump nop isr_pc isr_pipe / branch jump_flush mul div
        logic [1:0]  mode;    // same_pc jalr
        logic [3:0]  id_use;  // opA opB stype opBR
        logic [2:0]  ex_use;  // comp useA useB
        logic [2:0]  wr_en;   // exe mem wb
        logic [8:0]  sel;     // exe mem wb, one octal digit each
        logic [27:0] regs;    // id_rsA id_rsB exe_rsA exe_rsB exe_rd mem_rd wb_rd
    } stim_t;

    logic                 clk;
    logic                 nrst;
    logic [PC_W-1:0]      if_pc;
    logic [PC_W-1:0]      id_pc;
    logic                 is_jump, is_nop, isr_pc_flush, isr_pipe_flush;
    logic                 branch_flush, jump_flush, mul_stall, div_running;
    logic [REG_IDX_W-1:0] id_rsA, id_rsB, exe_rsA, exe_rsB;
    logic [REG_IDX_W-1:0] exe_rd, mem_rd, wb_rd;
    logic                 exe_wr_en, mem_wr_en, wb_wr_en;
    logic                 id_sel_opA, id_sel_opB, id_is_stype, id_sel_opBR;
    logic [WBSEL_W-1:0]   exe_sel_data, mem_sel_data, wb_sel_data;
    logic [OPC_W-1:0]     id_opcode;
    logic                 exe_comp_use_A, exe_comp_use_B, exe_is_comp;

    logic                 if_stall, id_stall, exe_stall;
    logic                 if_flush, id_flush, exe_flush, mem_flush;
    logic                 if_clk_en, id_clk_en, exe_clk_en, mem_clk_en, wb_clk_en, rf_clk_en;
    logic                 fw_exe_to_id_A, fw_exe_to_id_B, fw_mem_to_id_A, fw_mem_to_id_B;
    logic                 fw_wb_to_id_A, fw_wb_to_id_B, fw_wb_to_exe_A, fw_wb_to_exe_B;
    logic                 load_hazard;

    stim_t                stim_tbl [NROWS];
    logic [NOUT-1:0]      exp_tbl [NROWS];
    int                   errors;
    int                   checks;

    // Names in output vector order, MSB first
    string out_names [NOUT] = '{
        "if_stall", "id_stall", "exe_stall",
        "if_flush", "id_flush", "exe_flush", "mem_flush",
        "if_clk_en", "id_clk_en", "exe_clk_en", "mem_clk_en", "wb_clk_en", "rf_clk_en",
        "fw_exe_to_id_A", "fw_exe_to_id_B", "fw_mem_to_id_A", "fw_mem_to_id_B",
        "fw_wb_to_id_A", "fw_wb_to_id_B", "fw_wb_to_exe_A", "fw_wb_to_exe_B",
        "load_hazard"
    };

    sf_controller sf_controller_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Expected groups: stalls | flushes | enables if id exe mem wb rf | forwarding | load_hazard
    // Shadow state in the comments is {id exe mem wb}_prev_flush at that row
    task automatic load_table();
        stim_tbl[ 0] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[ 0]  = 22'b000_0000_111110_00000000_0;   // Idle, no WB write
        stim_tbl[ 1] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000000};
        exp_tbl[ 1]  = 22'b000_0000_111111_00000000_0;   // rf_clk_en follows wb_wr_en
        stim_tbl[ 2] = {8'b0000_0000, 2'b00, 4'b1000, 3'b000, 3'b111, 9'o000, 28'h1200111};
        exp_tbl[ 2]  = 22'b000_0000_111111_10000000_0;   // EXE beats MEM and WB
        stim_tbl[ 3] = {8'b0000_0000, 2'b00, 4'b1000, 3'b000, 3'b111, 9'o100, 28'h1200111};
        exp_tbl[ 3]  = 22'b000_0000_111111_00100000_0;   // Load in EXE, MEM wins
        stim_tbl[ 4] = {8'b0000_0000, 2'b00, 4'b1010, 3'b000, 3'b111, 9'o000, 28'h1200112};
        exp_tbl[ 4]  = 22'b000_0000_111111_10000100_0;   // Store data from WB
        stim_tbl[ 5] = {8'b0000_0000, 2'b00, 4'b1100, 3'b000, 3'b111, 9'o000, 28'h1200221};
        exp_tbl[ 5]  = 22'b000_0000_111111_01001000_0;   // A from WB, B from EXE
        stim_tbl[ 6] = {8'b0000_0000, 2'b00, 4'b1100, 3'b000, 3'b111, 9'o000, 28'h0000000};
        exp_tbl[ 6]  = 22'b000_0000_111111_00000000_0;   // x0 never forwards
        stim_tbl[ 7] = {8'b0000_0000, 2'b00, 4'b1100, 3'b000, 3'b000, 9'o000, 28'h1100111};
        exp_tbl[ 7]  = 22'b000_0000_111110_00000000_0;   // No write enables
        stim_tbl[ 8] = {8'b0000_0000, 2'b00, 4'b0001, 3'b000, 3'b111, 9'o000, 28'h1300133};
        exp_tbl[ 8]  = 22'b000_0000_111111_00010000_0;   // Branch rs2 from MEM
        stim_tbl[ 9] = {8'b0000_0000, 2'b00, 4'b0000, 3'b110, 3'b010, 9'o010, 28'h0045640};
        exp_tbl[ 9]  = 22'b111_0001_000010_00000000_1;   // Load-use on A
        stim_tbl[10] = {8'b0000_0000, 2'b00, 4'b0000, 3'b110, 3'b010, 9'o010, 28'h0045640};
        exp_tbl[10]  = 22'b000_0000_111100_00000000_0;   // 0010, hazard suppressed
        stim_tbl[11] = {8'b0000_0000, 2'b00, 4'b0000, 3'b111, 3'b001, 9'o001, 28'h0044604};
        exp_tbl[11]  = 22'b000_0000_111110_00000000_0;   // 0001, WB load masked
        stim_tbl[12] = {8'b0000_0000, 2'b00, 4'b0000, 3'b111, 3'b001, 9'o001, 28'h0044604};
        exp_tbl[12]  = 22'b000_0000_111111_00000011_0;   // WB load feeds both EXE operands
        stim_tbl[13] = {8'b0000_0000, 2'b00, 4'b0000, 3'b101, 3'b010, 9'o010, 28'h0045650};
        exp_tbl[13]  = 22'b111_0001_000010_00000000_1;   // Load-use on B
        stim_tbl[14] = {8'b0100_0000, 2'b00, 4'b0000, 3'b001, 3'b010, 9'o010, 28'h0045650};
        exp_tbl[14]  = 22'b000_0010_111100_00000000_0;   // Not a compute op, NOP in ID
        stim_tbl[15] = {8'b0000_0010, 2'b00, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[15]  = 22'b111_0001_000010_00000000_0;   // 0101, mul_stall
        stim_tbl[16] = {8'b0000_0001, 2'b00, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[16]  = 22'b111_0001_000000_00000000_0;   // 0010, div_running
        stim_tbl[17] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[17]  = 22'b000_0000_111100_00000000_0;   // 0011, no RF write
        stim_tbl[18] = {8'b0000_0000, 2'b01, 4'b1000, 3'b000, 3'b100, 9'o100, 28'h8000800};
        exp_tbl[18]  = 22'b110_0010_001110_00000000_0;   // Load then JALR
        stim_tbl[19] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[19]  = 22'b000_0000_111010_00000000_0;   // 0100
        stim_tbl[20] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[20]  = 22'b000_0000_111100_00000000_0;   // 0010
        stim_tbl[21] = {8'b0000_1000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[21]  = 22'b000_0110_111110_00000000_0;   // 0001, branch_flush
        stim_tbl[22] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[22]  = 22'b000_0000_110011_00000000_0;   // 1100
        stim_tbl[23] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[23]  = 22'b000_0000_111001_00000000_0;   // 0110
        stim_tbl[24] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[24]  = 22'b000_0000_111100_00000000_0;   // 0011
        stim_tbl[25] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[25]  = 22'b000_0000_111110_00000000_0;   // 0001
        stim_tbl[26] = {8'b0011_0100, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[26]  = 22'b000_1100_111111_00000000_0;   // Interrupt entry plus jump
        stim_tbl[27] = {8'b0000_0000, 2'b00, 4'b0000, 3'b000, 3'b001, 9'o000, 28'h0000007};
        exp_tbl[27]  = 22'b000_0000_111111_00000000_0;   // Chain entry was blocked
        stim_tbl[28] = {8'b1000_0000, 2'b10, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[28]  = 22'b000_0000_001110_00000000_0;   // Self-jump freeze
        stim_tbl[29] = {8'b1000_0000, 2'b10, 4'b0001, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[29]  = 22'b000_0000_110110_00000000_0;   // 1000, branch form
        stim_tbl[30] = {8'b1001_0000, 2'b10, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[30]  = 22'b000_0100_111010_00000000_0;   // 0100, interrupt wins
        stim_tbl[31] = {8'b1000_0010, 2'b10, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[31]  = 22'b111_0001_000000_00000000_0;   // 0010, stalled so no freeze
        stim_tbl[32] = {8'b0000_0100, 2'b00, 4'b0000, 3'b000, 3'b000, 9'o000, 28'h0000000};
        exp_tbl[32]  = 22'b000_0100_111100_00000000_0;   // 0011, jump_flush alone
    endtask

    task automatic apply_row(input stim_t s);
        {is_jump, is_nop, isr_pc_flush, isr_pipe_flush} = s.ctl[7:4];
        {branch_flush, jump_flush, mul_stall, div_running} = s.ctl[3:0];
        id_pc     = s.mode[1] ? 12'h100 : 12'h0fc;   // Same PC or the previous word
        id_opcode = s.mode[0] ? OPC_JALR : OPC_OP;
        {id_sel_opA, id_sel_opB, id_is_stype, id_sel_opBR} = s.id_use;
        {exe_is_comp, exe_comp_use_A, exe_comp_use_B} = s.ex_use;
        {exe_wr_en, mem_wr_en, wb_wr_en} = s.wr_en;
        {exe_sel_data, mem_sel_data, wb_sel_data} = s.sel;
        id_rsA  = {1'b0, s.regs[27:24]};
        id_rsB  = {1'b0, s.regs[23:20]};
        exe_rsA = {1'b0, s.regs[19:16]};
        exe_rsB = {1'b0, s.regs[15:12]};
        exe_rd  = {1'b0, s.regs[11:8]};
        mem_rd  = {1'b0, s.regs[7:4]};
        wb_rd   = {1'b0, s.regs[3:0]};
    endtask

    function automatic logic [NOUT-1:0] dut_outputs();
        return {if_stall, id_stall, exe_stall,
                if_flush, id_flush, exe_flush, mem_flush,
                if_clk_en, id_clk_en, exe_clk_en, mem_clk_en, wb_clk_en, rf_clk_en,
                fw_exe_to_id_A, fw_exe_to_id_B, fw_mem_to_id_A, fw_mem_to_id_B,
                fw_wb_to_id_A, fw_wb_to_id_B, fw_wb_to_exe_A, fw_wb_to_exe_B,
                load_hazard};
    endfunction

    // One check per output bit, X counts as wrong
    task automatic check_row(input int r);
        logic [NOUT-1:0] act;
        act = dut_outputs();
        for (int b = NOUT - 1; b >= 0; b--) begin
            checks++;
            assert (act[b] === exp_tbl[r][b]) else begin
                $display("** Error at time %0t: row %0d %s expected %b got %b",
                         $time, r, out_names[NOUT-1-b], exp_tbl[r][b], act[b]);
                errors++;
            end
        end
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Run timed out at %0t before the table finished", $time);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk    = 1'b0;
        nrst   = 1'b0;
        errors = 0;
        checks = 0;
        if_pc  = 12'h100;   // IF PC fixed, id_pc moves around it
        apply_row('0);
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            apply_row(stim_tbl[r]);
            #(CLK_PERIOD / 2 - 1);   // Just before the rising edge
            check_row(r);
            @(negedge clk);
        end
        $display("%0d checks over %0d rows, %0d errors", checks, NROWS, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verification/sf_controller_properties.sv */
module sf_controller_properties (
    input logic clk,
    input logic nrst,
    input logic if_stall,
    input logic id_stall,
    input logic id_flush,
    input logic isr_pipe_flush,
    input logic exe_clk_en,
    input logic rf_clk_en,
    input logic wb_wr_en,
    input logic fw_exe_to_id_A, fw_mem_to_id_A, fw_wb_to_id_A,
    input logic fw_exe_to_id_B, fw_mem_to_id_B, fw_wb_to_id_B
);

    // IF and ID always hold together
    stall_pair: assert property (@(posedge clk) disable iff (!nrst) if_stall == id_stall)
        else $error("if_stall and id_stall differ");

    // One source per ID operand at most
    id_src_a_onehot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0({fw_exe_to_id_A, fw_mem_to_id_A, fw_wb_to_id_A}))
        else $error("Several ID forwarding sources for operand A");
    id_src_b_onehot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0({fw_exe_to_id_B, fw_mem_to_id_B, fw_wb_to_id_B}))
        else $error("Several ID forwarding sources for operand B");

    rf_needs_wr_en: assert property (@(posedge clk) disable iff (!nrst) rf_clk_en |-> wb_wr_en)
        else $error("Register file enabled without wb_wr_en");

    // Flushed ID leaves a bubble that EXE must not latch
    flush_blocks_exe: assert property (@(posedge clk) disable iff (!nrst)
        (id_flush && !isr_pipe_flush) |=> !exe_clk_en)
        else $error("exe_clk_en high one cycle after id_flush");

endmodule

bind sf_controller sf_controller_properties sf_controller_props_inst (.*);

/* design/sf_controller.sv */
module sf_controller import pipe_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 nrst,

    // PCs for self-jump detection
    input  logic [PC_W-1:0]      if_pc,
    input  logic [PC_W-1:0]      id_pc,

    // Status from decode, interrupt controller, BHT and mul/div
    input  logic                 is_jump,
    input  logic                 is_nop,          // NOP in ID
    input  logic                 isr_pc_flush,
    input  logic                 isr_pipe_flush,
    input  logic                 branch_flush,    // Mispredict
    input  logic                 jump_flush,
    input  logic                 mul_stall,
    input  logic                 div_running,

    // Forwarding inputs
    input  logic [REG_IDX_W-1:0] id_rsA,
    input  logic [REG_IDX_W-1:0] id_rsB,
    input  logic [REG_IDX_W-1:0] exe_rsA,
    input  logic [REG_IDX_W-1:0] exe_rsB,
    input  logic [REG_IDX_W-1:0] exe_rd,
    input  logic [REG_IDX_W-1:0] mem_rd,
    input  logic [REG_IDX_W-1:0] wb_rd,
    input  logic                 exe_wr_en,
    input  logic                 mem_wr_en,
    input  logic                 wb_wr_en,
    input  logic                 id_sel_opA,
    input  logic                 id_sel_opB,
    input  logic                 id_is_stype,
    input  logic                 id_sel_opBR,
    input  logic [WBSEL_W-1:0]   exe_sel_data,
    input  logic [WBSEL_W-1:0]   mem_sel_data,
    input  logic [WBSEL_W-1:0]   wb_sel_data,
    input  logic [OPC_W-1:0]     id_opcode,
    input  logic                 exe_comp_use_A,
    input  logic                 exe_comp_use_B,
    input  logic                 exe_is_comp,

    // Stalls
    output logic                 if_stall,    // PC and instruction memory
    output logic                 id_stall,    // IF/ID register
    output logic                 exe_stall,   // ID/EXE register

    // Flushes, act as synchronous clears of the stage registers
    output logic                 if_flush,
    output logic                 id_flush,
    output logic                 exe_flush,
    output logic                 mem_flush,

    // Clock enables
    output logic                 if_clk_en,
    output logic                 id_clk_en,
    output logic                 exe_clk_en,
    output logic                 mem_clk_en,
    output logic                 wb_clk_en,
    output logic                 rf_clk_en,   // Register file write

    // Forwarding selects
    output logic                 fw_exe_to_id_A,
    output logic                 fw_exe_to_id_B,
    output logic                 fw_mem_to_id_A,
    output logic                 fw_mem_to_id_B,
    output logic                 fw_wb_to_id_A,
    output logic                 fw_wb_to_id_B,
    output logic                 fw_wb_to_exe_A,
    output logic                 fw_wb_to_exe_B,

    output logic                 load_hazard  // Load followed by a user in EXE
);

    logic hzd_exe_to_id_A;
    logic hzd_mem_to_exe_A;
    logic hzd_mem_to_exe_B;
    logic wb_exe_hit_a;     // Before bubble masking
    logic wb_exe_hit_b;

    logic id_prev_flush;
    logic exe_prev_flush;
    logic mem_prev_flush;
    logic wb_prev_flush;

    logic jalr_hazard;
    logic loop_jump;
    logic hold_front;       // Common stall sources
    logic loop_freeze;

    forwarding_unit fwd_unit_inst (
        .id_rsA           (id_rsA),
        .id_rsB           (id_rsB),
        .exe_rsA          (exe_rsA),
        .exe_rsB          (exe_rsB),
        .exe_rd           (exe_rd),
        .mem_rd           (mem_rd),
        .wb_rd            (wb_rd),
        .exe_wr_en        (exe_wr_en),
        .mem_wr_en        (mem_wr_en),
        .wb_wr_en         (wb_wr_en),
        .id_sel_opA       (id_sel_opA),
        .id_sel_opB       (id_sel_opB),
        .id_is_stype      (id_is_stype),
        .id_sel_opBR      (id_sel_opBR),
        .exe_sel_data     (exe_sel_data),
        .mem_sel_data     (mem_sel_data),
        .wb_sel_data      (wb_sel_data),
        .id_opcode        (id_opcode),
        .exe_comp_use_A   (exe_comp_use_A),
        .exe_comp_use_B   (exe_comp_use_B),
        .exe_is_comp      (exe_is_comp),
        .fw_exe_to_id_A   (fw_exe_to_id_A),
        .fw_exe_to_id_B   (fw_exe_to_id_B),
        .fw_mem_to_id_A   (fw_mem_to_id_A),
        .fw_mem_to_id_B   (fw_mem_to_id_B),
        .fw_wb_to_id_A    (fw_wb_to_id_A),
        .fw_wb_to_id_B    (fw_wb_to_id_B),
        .fw_wb_to_exe_A   (wb_exe_hit_a),
        .fw_wb_to_exe_B   (wb_exe_hit_b),
        .hzd_exe_to_id_A  (hzd_exe_to_id_A),
        .hzd_mem_to_exe_A (hzd_mem_to_exe_A),
        .hzd_mem_to_exe_B (hzd_mem_to_exe_B)
    );

    flush_tracker flush_tracker_inst (
        .clk            (clk),
        .nrst           (nrst),
        .id_flush       (id_flush),
        .exe_flush      (exe_flush),
        .mem_flush      (mem_flush),
        .loop_jump      (loop_jump),
        .isr_pipe_flush (isr_pipe_flush),
        .id_prev_flush  (id_prev_flush),
        .exe_prev_flush (exe_prev_flush),
        .mem_prev_flush (mem_prev_flush),
        .wb_prev_flush  (wb_prev_flush)
    );

    // A bubble in MEM carries no real load
    assign load_hazard = (hzd_mem_to_exe_A || hzd_mem_to_exe_B) && !mem_prev_flush;
    assign jalr_hazard = hzd_exe_to_id_A;   // One-cycle hold of IF and ID

    // Jump onto itself, keep fetching nothing new
    assign loop_jump = (if_pc == id_pc) && is_jump && !id_sel_opBR && !id_stall;

    assign hold_front = load_hazard || div_running || mul_stall;

    assign if_stall  = hold_front || jalr_hazard;
    assign id_stall  = hold_front || jalr_hazard;
    assign exe_stall = hold_front;   // JALR bubble goes into EXE instead

    assign if_flush  = isr_pc_flush;
    assign id_flush  = isr_pipe_flush || jump_flush || branch_flush;
    assign exe_flush = jalr_hazard || branch_flush || is_nop;
    assign mem_flush = hold_front;   // Bubble behind the held EXE

    // Interrupt entry overrides the self-jump freeze
    assign loop_freeze = loop_jump && !isr_pipe_flush;

    assign if_clk_en  = !(if_stall || loop_freeze);
    assign id_clk_en  = !(id_stall || loop_freeze);
    assign exe_clk_en = !(exe_stall || id_prev_flush);
    assign mem_clk_en = !(mem_flush || exe_prev_flush);
    assign wb_clk_en  = !mem_prev_flush;
    assign rf_clk_en  = wb_wr_en && !wb_prev_flush;   // No write from a bubble

    // Flushed WB holds stale load data
    assign fw_wb_to_exe_A = wb_exe_hit_a && !wb_prev_flush;
    assign fw_wb_to_exe_B = wb_exe_hit_b && !wb_prev_flush;

endmodule

/* design/flush_tracker.sv */
module flush_tracker (
    input  logic clk,
    input  logic nrst,

    // Flush requests of this cycle
    input  logic id_flush,
    input  logic exe_flush,
    input  logic mem_flush,
    input  logic loop_jump,       // Self-jump bubble entering ID
    input  logic isr_pipe_flush,  // Interrupt entry wipes the pipe anyway

    // Stage holds a flushed bubble
    output logic id_prev_flush,
    output logic exe_prev_flush,
    output logic mem_prev_flush,
    output logic wb_prev_flush
);

    logic id_entry;   // Bubble entering the chain at ID

    assign id_entry = (id_flush || loop_jump) && !isr_pipe_flush;

    // Shadow chain moves one stage per clock, stalls or not
    always_ff @(posedge clk) begin
        if (!nrst) begin
            id_prev_flush  <= 1'b0;
            exe_prev_flush <= 1'b0;
            mem_prev_flush <= 1'b0;
            wb_prev_flush  <= 1'b0;
        end else begin
            id_prev_flush  <= id_entry;
            // Older bubble has priority over a fresh request
            exe_prev_flush <= id_prev_flush  ? 1'b1 : exe_flush;
            mem_prev_flush <= exe_prev_flush ? 1'b1 : mem_flush;
            wb_prev_flush  <= mem_prev_flush;   // WB never flushes itself
        end
    end

endmodule

/* design/forwarding_unit.sv */
module forwarding_unit import pipe_ctrl_pkg::*; (
    // Source registers
    input  logic [REG_IDX_W-1:0] id_rsA,
    input  logic [REG_IDX_W-1:0] id_rsB,
    input  logic [REG_IDX_W-1:0] exe_rsA,
    input  logic [REG_IDX_W-1:0] exe_rsB,

    // Destination registers
    input  logic [REG_IDX_W-1:0] exe_rd,
    input  logic [REG_IDX_W-1:0] mem_rd,
    input  logic [REG_IDX_W-1:0] wb_rd,

    // Register write enables per stage
    input  logic                 exe_wr_en,
    input  logic                 mem_wr_en,
    input  logic                 wb_wr_en,

    // ID operand sources
    input  logic                 id_sel_opA,   // rs1 feeds operand A
    input  logic                 id_sel_opB,   // rs2 feeds operand B
    input  logic                 id_is_stype,  // Store data comes from rs2
    input  logic                 id_sel_opBR,  // Branch compare reads rs2

    // Write-back selects of the older stages
    input  logic [WBSEL_W-1:0]   exe_sel_data,
    input  logic [WBSEL_W-1:0]   mem_sel_data,
    input  logic [WBSEL_W-1:0]   wb_sel_data,

    input  logic [OPC_W-1:0]     id_opcode,

    // EXE operand usage
    input  logic                 exe_comp_use_A,
    input  logic                 exe_comp_use_B,
    input  logic                 exe_is_comp,

    // Forwarding into ID
    output logic                 fw_exe_to_id_A,
    output logic                 fw_exe_to_id_B,
    output logic                 fw_mem_to_id_A,
    output logic                 fw_mem_to_id_B,
    output logic                 fw_wb_to_id_A,
    output logic                 fw_wb_to_id_B,

    // Forwarding into EXE
    output logic                 fw_wb_to_exe_A,
    output logic                 fw_wb_to_exe_B,

    // RAW hazards that need a stall
    output logic                 hzd_exe_to_id_A,   // Load in EXE, JALR in ID
    output logic                 hzd_mem_to_exe_A,  // Load in MEM, user in EXE
    output logic                 hzd_mem_to_exe_B
);

    // Stage will write rs back to the register file
    function automatic logic stage_writes(
        input logic                 wr_en,
        input logic [REG_IDX_W-1:0] rd,
        input logic [REG_IDX_W-1:0] rs
    );
        return wr_en && (rd == rs) && (rs != REG_ZERO);
    endfunction

    // One-hot {exe, mem, wb} source, youngest result first
    function automatic logic [2:0] pick_source(
        input logic used,
        input logic exe_hit,
        input logic mem_hit,
        input logic wb_hit
    );
        logic [2:0] sel;
        sel = 3'b000;
        if (used) begin
            if (exe_hit)
                sel = 3'b100;
            else if (mem_hit)
                sel = 3'b010;
            else if (wb_hit)
                sel = 3'b001;
        end
        return sel;
    endfunction

    logic       exe_is_load;
    logic       mem_is_load;
    logic       wb_is_load;

    logic       id_use_a;
    logic       id_use_b;
    logic       exe_use_a;
    logic       exe_use_b;

    logic       exe_writes_a;   // EXE rd matches id_rsA
    logic       exe_writes_b;
    logic       exe_hit_a;      // EXE result already available
    logic       exe_hit_b;
    logic       mem_hit_a;
    logic       mem_hit_b;
    logic       wb_hit_a;
    logic       wb_hit_b;

    logic [2:0] id_src_a;
    logic [2:0] id_src_b;

    assign exe_is_load = (exe_sel_data == WB_SEL_LOAD);
    assign mem_is_load = (mem_sel_data == WB_SEL_LOAD);
    assign wb_is_load  = (wb_sel_data == WB_SEL_LOAD);

    // Which ID operands actually come from the register file
    assign id_use_a = id_sel_opA;
    assign id_use_b = id_sel_opB || id_is_stype || id_sel_opBR;

    // EXE operands only matter for compute instructions
    assign exe_use_a = exe_is_comp && exe_comp_use_A;
    assign exe_use_b = exe_is_comp && exe_comp_use_B;

    // Matches against ID sources
    assign exe_writes_a = stage_writes(exe_wr_en, exe_rd, id_rsA);
    assign exe_writes_b = stage_writes(exe_wr_en, exe_rd, id_rsB);
    assign exe_hit_a    = exe_writes_a && !exe_is_load;   // Load data not read yet
    assign exe_hit_b    = exe_writes_b && !exe_is_load;
    assign mem_hit_a    = stage_writes(mem_wr_en, mem_rd, id_rsA);
    assign mem_hit_b    = stage_writes(mem_wr_en, mem_rd, id_rsB);
    assign wb_hit_a     = stage_writes(wb_wr_en, wb_rd, id_rsA);
    assign wb_hit_b     = stage_writes(wb_wr_en, wb_rd, id_rsB);

    assign id_src_a = pick_source(id_use_a, exe_hit_a, mem_hit_a, wb_hit_a);
    assign id_src_b = pick_source(id_use_b, exe_hit_b, mem_hit_b, wb_hit_b);

    assign {fw_exe_to_id_A, fw_mem_to_id_A, fw_wb_to_id_A} = id_src_a;
    assign {fw_exe_to_id_B, fw_mem_to_id_B, fw_wb_to_id_B} = id_src_b;

    // JALR needs rs1 in ID, a load in EXE cannot supply it
    assign hzd_exe_to_id_A = exe_writes_a && exe_is_load && (id_opcode == OPC_JALR);

    // Load in MEM has no data until it reaches WB
    assign hzd_mem_to_exe_A = exe_use_a && mem_is_load &&
                              stage_writes(mem_wr_en, mem_rd, exe_rsA);
    assign hzd_mem_to_exe_B = exe_use_b && mem_is_load &&
                              stage_writes(mem_wr_en, mem_rd, exe_rsB);

    // Same load one stage later, now forwardable from WB
    assign fw_wb_to_exe_A = exe_use_a && wb_is_load &&
                            stage_writes(wb_wr_en, wb_rd, exe_rsA);
    assign fw_wb_to_exe_B = exe_use_b && wb_is_load &&
                            stage_writes(wb_wr_en, wb_rd, exe_rsB);

endmodule

/* design/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // Register file index, x0 to x31
    localparam int REG_IDX_W = 5;

    // Only the low PC bits reach the controller
    localparam int PC_W = 12;   // Enough to spot a jump onto itself

    // Major opcode field of a 32-bit instruction
    localparam int OPC_W = 7;

    // Per-stage write-back data select
    localparam int WBSEL_W = 3;

    // Write-back data select codes
    // Each stage carries one of these alongside its rd
    localparam logic [WBSEL_W-1:0] WB_SEL_ALU  = 3'd0;  // ALU or multiplier result
    localparam logic [WBSEL_W-1:0] WB_SEL_LOAD = 3'd1;  // Data memory, instruction is a load
    localparam logic [WBSEL_W-1:0] WB_SEL_PC4  = 3'd2;  // Link address of JAL/JALR

    // JALR reads rs1 in ID to form its target
    localparam logic [OPC_W-1:0] OPC_JALR = 7'b1100111;

    // x0 is hardwired to zero
    // A write to it never creates a dependency
    localparam logic [REG_IDX_W-1:0] REG_ZERO = '0;

endpackage
